// File: verilog/cluster_pkg.sv
// Cluster package
// Group count, opcode and link direction encodings, address split helpers
`default_nettype none

package cluster_pkg;

  // Four groups, fixed by the XOR link topology
  localparam int unsigned NumGroups    = 4;
  localparam int unsigned GroupIdWidth = 2;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_SWAP  = 2'd2
  } mem_op_e;

  // Encoding equals source index XOR target index
  typedef enum logic [1:0] {
    DIR_LOCAL     = 2'd0,
    DIR_EAST      = 2'd1,
    DIR_NORTH     = 2'd2,
    DIR_NORTHEAST = 2'd3
  } link_dir_e;

  // Word index bits inside one bank
  function automatic int unsigned index_width(int unsigned bank_words);
    return $clog2(bank_words);
  endfunction

  // Target group on top, word index below
  function automatic int unsigned addr_width(int unsigned bank_words);
    return GroupIdWidth + $clog2(bank_words);
  endfunction

endpackage : cluster_pkg

`default_nettype wire

// File: verilog/group_bank.sv
// Group bank
// Word array shared by the local router and the three incoming links.
// One source is granted per cycle, round-robin, with a registered response.
`timescale 1ns/1ns
`default_nettype none

module group_bank
  import cluster_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned BankWords = 256
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // Requests, indexed by link direction
  input  logic    [NumGroups-1:0]                             src_valid_i,
  input  mem_op_e [NumGroups-1:0]                             src_op_i,
  input  logic    [NumGroups-1:0][index_width(BankWords)-1:0] src_index_i,
  input  logic    [NumGroups-1:0][DataWidth-1:0]              src_wdata_i,
  output logic    [NumGroups-1:0]                             src_grant_o,
  // Responses, one source per cycle so the data is shared
  output logic    [NumGroups-1:0]                             src_resp_valid_o,
  output logic    [DataWidth-1:0]                             src_resp_rdata_o
);

  localparam int unsigned IndexWidth = index_width(BankWords);

  logic [DataWidth-1:0]    mem_q [BankWords];
  logic [GroupIdWidth-1:0] rr_ptr_q;
  logic [GroupIdWidth-1:0] grant_idx;
  logic                    grant_valid;
  mem_op_e                 sel_op;
  logic [IndexWidth-1:0]   sel_index;
  logic [DataWidth-1:0]    sel_wdata;
  logic [NumGroups-1:0]    resp_valid_q;
  logic [DataWidth-1:0]    rdata_q;

  // First valid source at or after the pointer
  always_comb begin
    logic [GroupIdWidth-1:0] cand;
    cand        = rr_ptr_q;
    grant_valid = 1'b0;
    grant_idx   = rr_ptr_q;
    for (int unsigned i = 0; i < NumGroups; i++) begin
      cand = rr_ptr_q + GroupIdWidth'(i);
      if (!grant_valid && src_valid_i[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  always_comb begin
    src_grant_o = '0;
    if (grant_valid) begin
      src_grant_o[grant_idx] = 1'b1;
    end
  end

  assign sel_op    = src_op_i[grant_idx];
  assign sel_index = src_index_i[grant_idx];
  assign sel_wdata = src_wdata_i[grant_idx];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q     <= DIR_LOCAL;
      resp_valid_q <= '0;
    end else begin
      resp_valid_q <= src_grant_o;
      // Next search starts just past the winner
      if (grant_valid) begin
        rr_ptr_q <= grant_idx + GroupIdWidth'(1);
      end
    end
  end

  // Array access on the grant edge
  always_ff @(posedge clk_i) begin
    if (grant_valid) begin
      case (sel_op)
        OP_WRITE: begin
          mem_q[sel_index] <= sel_wdata;
          rdata_q          <= '0;
        end
        OP_SWAP: begin
          mem_q[sel_index] <= sel_wdata;
          rdata_q          <= mem_q[sel_index];
        end
        default: begin
          rdata_q <= mem_q[sel_index];
        end
      endcase
    end
  end

  assign src_resp_valid_o = resp_valid_q;
  assign src_resp_rdata_o = rdata_q;

endmodule : group_bank

`default_nettype wire

// File: verilog/group_router.sv
// Group router
// External request port of one group. Decodes the target group, drives the
// request on one link direction until granted and forwards the response.
`timescale 1ns/1ns
`default_nettype none

module group_router
  import cluster_pkg::*;
#(
  parameter int unsigned GroupId   = 0,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned BankWords = 256
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // External port
  input  logic                                                req_valid_i,
  input  mem_op_e                                             req_op_i,
  input  logic    [addr_width(BankWords)-1:0]                 req_addr_i,
  input  logic    [DataWidth-1:0]                             req_wdata_i,
  output logic                                                req_ready_o,
  output logic                                                resp_valid_o,
  output logic    [DataWidth-1:0]                             resp_rdata_o,
  // Links, indexed by direction
  output logic    [NumGroups-1:0]                             out_valid_o,
  output mem_op_e [NumGroups-1:0]                             out_op_o,
  output logic    [NumGroups-1:0][index_width(BankWords)-1:0] out_index_o,
  output logic    [NumGroups-1:0][DataWidth-1:0]              out_wdata_o,
  input  logic    [NumGroups-1:0]                             out_grant_i,
  input  logic    [NumGroups-1:0]                             out_resp_valid_i,
  input  logic    [NumGroups-1:0][DataWidth-1:0]              out_resp_rdata_i
);

  localparam int unsigned IndexWidth = index_width(BankWords);
  localparam int unsigned AddrWidth  = addr_width(BankWords);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RESP
  } state_e;

  state_e                state_q;
  state_e                state_d;
  link_dir_e             dir_q;
  link_dir_e             dir_req;
  mem_op_e               op_q;
  logic [IndexWidth-1:0] index_q;
  logic [DataWidth-1:0]  wdata_q;
  logic                  accept;
  logic                  resp_hit;

  // Direction is own index XOR target index
  assign dir_req = link_dir_e'(GroupIdWidth'(GroupId)
                               ^ req_addr_i[AddrWidth-1 -: GroupIdWidth]);

  assign resp_hit     = (state_q == WAIT_RESP) && out_resp_valid_i[dir_q];
  assign req_ready_o  = (state_q == IDLE) || resp_hit;
  assign accept       = req_valid_i && req_ready_o;
  assign resp_valid_o = resp_hit;
  assign resp_rdata_o = out_resp_rdata_i[dir_q];

  always_comb begin
    state_d = state_q;
    case (state_q)
      ISSUE: begin
        if (out_grant_i[dir_q]) begin
          state_d = WAIT_RESP;
        end
      end
      WAIT_RESP: begin
        if (resp_hit) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = state_q;
      end
    endcase
    // Back-to-back request in the response cycle
    if (accept) begin
      state_d = ISSUE;
    end
  end

  always_comb begin
    out_valid_o        = '0;
    out_valid_o[dir_q] = (state_q == ISSUE);
    for (int unsigned d = 0; d < NumGroups; d++) begin
      out_op_o[d]    = op_q;
      out_index_o[d] = index_q;
      out_wdata_o[d] = wdata_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      dir_q   <= DIR_LOCAL;
    end else begin
      state_q <= state_d;
      if (accept) begin
        dir_q <= dir_req;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= req_op_i;
      index_q <= req_addr_i[IndexWidth-1:0];
      wdata_q <= req_wdata_i;
    end
  end

endmodule : group_router

`default_nettype wire

// File: verilog/memory_group.sv
// Memory group
// Router and bank of one group. The local direction stays inside;
// east, north and northeast leave as outgoing and incoming links.
`timescale 1ns/1ns
`default_nettype none

module memory_group
  import cluster_pkg::*;
#(
  parameter int unsigned GroupId   = 0,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned BankWords = 256
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic                                                req_valid_i,
  input  mem_op_e                                             req_op_i,
  input  logic    [addr_width(BankWords)-1:0]                 req_addr_i,
  input  logic    [DataWidth-1:0]                             req_wdata_i,
  output logic                                                req_ready_o,
  output logic                                                resp_valid_o,
  output logic    [DataWidth-1:0]                             resp_rdata_o,
  // Outgoing links, entry 0 is east
  output logic    [NumGroups-2:0]                             link_out_valid_o,
  output mem_op_e [NumGroups-2:0]                             link_out_op_o,
  output logic    [NumGroups-2:0][index_width(BankWords)-1:0] link_out_index_o,
  output logic    [NumGroups-2:0][DataWidth-1:0]              link_out_wdata_o,
  input  logic    [NumGroups-2:0]                             link_out_grant_i,
  input  logic    [NumGroups-2:0]                             link_out_resp_valid_i,
  input  logic    [NumGroups-2:0][DataWidth-1:0]              link_out_resp_rdata_i,
  // Incoming links into the bank
  input  logic    [NumGroups-2:0]                             link_in_valid_i,
  input  mem_op_e [NumGroups-2:0]                             link_in_op_i,
  input  logic    [NumGroups-2:0][index_width(BankWords)-1:0] link_in_index_i,
  input  logic    [NumGroups-2:0][DataWidth-1:0]              link_in_wdata_i,
  output logic    [NumGroups-2:0]                             link_in_grant_o,
  output logic    [NumGroups-2:0]                             link_in_resp_valid_o,
  output logic    [NumGroups-2:0][DataWidth-1:0]              link_in_resp_rdata_o
);

  localparam int unsigned IndexWidth = index_width(BankWords);

  // Router side, by direction
  logic    [NumGroups-1:0]                 rtr_valid;
  mem_op_e [NumGroups-1:0]                 rtr_op;
  logic    [NumGroups-1:0][IndexWidth-1:0] rtr_index;
  logic    [NumGroups-1:0][DataWidth-1:0]  rtr_wdata;
  logic    [NumGroups-1:0]                 rtr_grant;
  logic    [NumGroups-1:0]                 rtr_resp_valid;
  logic    [NumGroups-1:0][DataWidth-1:0]  rtr_resp_rdata;
  // Bank side, by source
  logic    [NumGroups-1:0]                 bank_valid;
  mem_op_e [NumGroups-1:0]                 bank_op;
  logic    [NumGroups-1:0][IndexWidth-1:0] bank_index;
  logic    [NumGroups-1:0][DataWidth-1:0]  bank_wdata;
  logic    [NumGroups-1:0]                 bank_grant;
  logic    [NumGroups-1:0]                 bank_resp_valid;
  logic    [DataWidth-1:0]                 bank_rdata;

  group_router #(
    .GroupId  (GroupId  ),
    .DataWidth(DataWidth),
    .BankWords(BankWords)
  ) i_router (
    .clk_i           (clk_i         ),
    .arst_n_i        (arst_n_i      ),
    .req_valid_i     (req_valid_i   ),
    .req_op_i        (req_op_i      ),
    .req_addr_i      (req_addr_i    ),
    .req_wdata_i     (req_wdata_i   ),
    .req_ready_o     (req_ready_o   ),
    .resp_valid_o    (resp_valid_o  ),
    .resp_rdata_o    (resp_rdata_o  ),
    .out_valid_o     (rtr_valid     ),
    .out_op_o        (rtr_op        ),
    .out_index_o     (rtr_index     ),
    .out_wdata_o     (rtr_wdata     ),
    .out_grant_i     (rtr_grant     ),
    .out_resp_valid_i(rtr_resp_valid),
    .out_resp_rdata_i(rtr_resp_rdata)
  );

  group_bank #(
    .DataWidth(DataWidth),
    .BankWords(BankWords)
  ) i_bank (
    .clk_i           (clk_i          ),
    .arst_n_i        (arst_n_i       ),
    .src_valid_i     (bank_valid     ),
    .src_op_i        (bank_op        ),
    .src_index_i     (bank_index     ),
    .src_wdata_i     (bank_wdata     ),
    .src_grant_o     (bank_grant     ),
    .src_resp_valid_o(bank_resp_valid),
    .src_resp_rdata_o(bank_rdata     )
  );

  // Local direction, router straight to bank
  assign bank_valid[DIR_LOCAL]     = rtr_valid[DIR_LOCAL];
  assign bank_op[DIR_LOCAL]        = rtr_op[DIR_LOCAL];
  assign bank_index[DIR_LOCAL]     = rtr_index[DIR_LOCAL];
  assign bank_wdata[DIR_LOCAL]     = rtr_wdata[DIR_LOCAL];
  assign rtr_grant[DIR_LOCAL]      = bank_grant[DIR_LOCAL];
  assign rtr_resp_valid[DIR_LOCAL] = bank_resp_valid[DIR_LOCAL];
  assign rtr_resp_rdata[DIR_LOCAL] = bank_rdata;

  // Remote directions leave the group
  assign link_out_valid_o                 = rtr_valid[NumGroups-1:1];
  assign link_out_op_o                    = rtr_op[NumGroups-1:1];
  assign link_out_index_o                 = rtr_index[NumGroups-1:1];
  assign link_out_wdata_o                 = rtr_wdata[NumGroups-1:1];
  assign rtr_grant[NumGroups-1:1]         = link_out_grant_i;
  assign rtr_resp_valid[NumGroups-1:1]    = link_out_resp_valid_i;
  assign rtr_resp_rdata[NumGroups-1:1]    = link_out_resp_rdata_i;

  assign bank_valid[NumGroups-1:1] = link_in_valid_i;
  assign bank_op[NumGroups-1:1]    = link_in_op_i;
  assign bank_index[NumGroups-1:1] = link_in_index_i;
  assign bank_wdata[NumGroups-1:1] = link_in_wdata_i;
  assign link_in_grant_o           = bank_grant[NumGroups-1:1];
  assign link_in_resp_valid_o      = bank_resp_valid[NumGroups-1:1];
  assign link_in_resp_rdata_o      = {(NumGroups-1){bank_rdata}};

endmodule : memory_group

`default_nettype wire

// File: verilog/memory_cluster.sv
// Memory cluster
// Four memory groups, each bank reachable from every group over fixed
// east, north and northeast links wired by XOR of the group indices.
`timescale 1ns/1ns
`default_nettype none

module memory_cluster
  import cluster_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned BankWords = 256
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic    [NumGroups-1:0]                             req_valid_i,
  input  mem_op_e [NumGroups-1:0]                             req_op_i,
  input  logic    [NumGroups-1:0][addr_width(BankWords)-1:0]  req_addr_i,
  input  logic    [NumGroups-1:0][DataWidth-1:0]              req_wdata_i,
  output logic    [NumGroups-1:0]                             req_ready_o,
  output logic    [NumGroups-1:0]                             resp_valid_o,
  output logic    [NumGroups-1:0][DataWidth-1:0]              resp_rdata_o
);

  localparam int unsigned IndexWidth = index_width(BankWords);
  localparam int unsigned NumLinks   = NumGroups - 1;

  // Indexed [group][link], link l carries direction l+1
  logic    [NumGroups-1:0][NumLinks-1:0]                 out_valid;
  mem_op_e [NumGroups-1:0][NumLinks-1:0]                 out_op;
  logic    [NumGroups-1:0][NumLinks-1:0][IndexWidth-1:0] out_index;
  logic    [NumGroups-1:0][NumLinks-1:0][DataWidth-1:0]  out_wdata;
  logic    [NumGroups-1:0][NumLinks-1:0]                 out_grant;
  logic    [NumGroups-1:0][NumLinks-1:0]                 out_resp_valid;
  logic    [NumGroups-1:0][NumLinks-1:0][DataWidth-1:0]  out_resp_rdata;
  logic    [NumGroups-1:0][NumLinks-1:0]                 in_valid;
  mem_op_e [NumGroups-1:0][NumLinks-1:0]                 in_op;
  logic    [NumGroups-1:0][NumLinks-1:0][IndexWidth-1:0] in_index;
  logic    [NumGroups-1:0][NumLinks-1:0][DataWidth-1:0]  in_wdata;
  logic    [NumGroups-1:0][NumLinks-1:0]                 in_grant;
  logic    [NumGroups-1:0][NumLinks-1:0]                 in_resp_valid;
  logic    [NumGroups-1:0][NumLinks-1:0][DataWidth-1:0]  in_resp_rdata;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    memory_group #(
      .GroupId  (g        ),
      .DataWidth(DataWidth),
      .BankWords(BankWords)
    ) i_group (
      .clk_i                (clk_i            ),
      .arst_n_i             (arst_n_i         ),
      .req_valid_i          (req_valid_i[g]   ),
      .req_op_i             (req_op_i[g]      ),
      .req_addr_i           (req_addr_i[g]    ),
      .req_wdata_i          (req_wdata_i[g]   ),
      .req_ready_o          (req_ready_o[g]   ),
      .resp_valid_o         (resp_valid_o[g]  ),
      .resp_rdata_o         (resp_rdata_o[g]  ),
      .link_out_valid_o     (out_valid[g]     ),
      .link_out_op_o        (out_op[g]        ),
      .link_out_index_o     (out_index[g]     ),
      .link_out_wdata_o     (out_wdata[g]     ),
      .link_out_grant_i     (out_grant[g]     ),
      .link_out_resp_valid_i(out_resp_valid[g]),
      .link_out_resp_rdata_i(out_resp_rdata[g]),
      .link_in_valid_i      (in_valid[g]      ),
      .link_in_op_i         (in_op[g]         ),
      .link_in_index_i      (in_index[g]      ),
      .link_in_wdata_i      (in_wdata[g]      ),
      .link_in_grant_o      (in_grant[g]      ),
      .link_in_resp_valid_o (in_resp_valid[g] ),
      .link_in_resp_rdata_o (in_resp_rdata[g] )
    );
  end : gen_groups

  // Direction d of group g meets direction d of group g XOR d
  for (genvar g = 0; g < NumGroups; g++) begin : gen_interconnect
    for (genvar l = 0; l < NumLinks; l++) begin : gen_link
      localparam int unsigned Peer = g ^ (l + 1);

      assign in_valid[Peer][l]    = out_valid[g][l];
      assign in_op[Peer][l]       = out_op[g][l];
      assign in_index[Peer][l]    = out_index[g][l];
      assign in_wdata[Peer][l]    = out_wdata[g][l];
      // Grant and response travel back the same link
      assign out_grant[g][l]      = in_grant[Peer][l];
      assign out_resp_valid[g][l] = in_resp_valid[Peer][l];
      assign out_resp_rdata[g][l] = in_resp_rdata[Peer][l];
    end : gen_link
  end : gen_interconnect

endmodule : memory_cluster

`default_nettype wire

// File: verif/cluster_assertions.sv
// Cluster protocol assertions
// Reset state, response latency bound and ready/response pairing per port
`timescale 1ns/1ns
`default_nettype none

module cluster_assertions
  import cluster_pkg::*;
(
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic [NumGroups-1:0] req_valid_i,
  input logic [NumGroups-1:0] req_ready_o,
  input logic [NumGroups-1:0] resp_valid_o
);

  localparam logic [2:0] MaxLatency = 3'd5;

  int unsigned          fail_count = 0;
  logic [NumGroups-1:0] accepted;
  logic [NumGroups-1:0] busy_q;
  logic [NumGroups-1:0] late;
  logic [2:0]           age_q [NumGroups];

  assign accepted = req_valid_i & req_ready_o;

  // Outstanding request and its age, counted from the acceptance edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= '0;
      for (int g = 0; g < NumGroups; g++) begin
        age_q[g] <= 3'd0;
      end
    end else begin
      for (int g = 0; g < NumGroups; g++) begin
        if (accepted[g]) begin
          busy_q[g] <= 1'b1;
          age_q[g]  <= 3'd1;
        end else if (resp_valid_o[g]) begin
          busy_q[g] <= 1'b0;
        end else if (busy_q[g] && age_q[g] != 3'd7) begin
          age_q[g] <= age_q[g] + 3'd1;
        end
      end
    end
  end

  always_comb begin
    for (int g = 0; g < NumGroups; g++) begin
      late[g] = busy_q[g] && (age_q[g] > MaxLatency);
    end
  end

  a_reset_state: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> (resp_valid_o == '0) && (req_ready_o == '1))
    else begin
      fail_count++;
      $error("port state wrong after reset release");
    end

  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    late == '0)
    else begin
      fail_count++;
      $error("response later than 5 cycles");
    end

  a_ready_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (busy_q & ~resp_valid_o & req_ready_o) == '0)
    else begin
      fail_count++;
      $error("ready high while request outstanding");
    end

  a_resp_owned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (resp_valid_o & ~busy_q) == '0)
    else begin
      fail_count++;
      $error("response without outstanding request");
    end

endmodule : cluster_assertions

bind memory_cluster cluster_assertions i_cluster_assertions (.*);

`default_nettype wire

// File: verif/tb_memory_cluster.sv
// Memory cluster testbench
// Drives all four group ports, checks read data against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_memory_cluster;
  import cluster_pkg::*;

  localparam int unsigned DataWidth      = 32;
  localparam int unsigned BankWords      = 256;
  localparam int unsigned AddrWidth      = 10;
  localparam int unsigned RandomPerGroup = 100;
  // Budget of about 5 cycles per request, the worst-case latency
  localparam int unsigned TotalRequests  = 32 + 32 + 12 + 32 + 2 + 4 * RandomPerGroup;
  localparam int unsigned CycleLimit     = TotalRequests * 5 + 200;

  logic                                  clk_i;
  logic                                  arst_n_i;
  logic    [NumGroups-1:0]               req_valid_i;
  mem_op_e [NumGroups-1:0]               req_op_i;
  logic    [NumGroups-1:0][AddrWidth-1:0] req_addr_i;
  logic    [NumGroups-1:0][DataWidth-1:0] req_wdata_i;
  logic    [NumGroups-1:0]               req_ready_o;
  logic    [NumGroups-1:0]               resp_valid_o;
  logic    [NumGroups-1:0][DataWidth-1:0] resp_rdata_o;

  logic [31:0] seed;
  int unsigned errors;
  int unsigned checks;
  int unsigned tests_run;
  int unsigned cycle_count;
  int unsigned errors_at_start;
  // Flat index is the full address, group bits on top
  logic [DataWidth-1:0] model_mem [NumGroups*BankWords];
  bit                   model_known [NumGroups*BankWords];

  memory_cluster #(
    .DataWidth(DataWidth),
    .BankWords(BankWords)
  ) i_dut (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .req_valid_i (req_valid_i ),
    .req_op_i    (req_op_i    ),
    .req_addr_i  (req_addr_i  ),
    .req_wdata_i (req_wdata_i ),
    .req_ready_o (req_ready_o ),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= CycleLimit) begin
      $display("Timeout: run exceeded %0d cycles", CycleLimit);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [AddrWidth-1:0] make_addr(logic [1:0] grp, logic [7:0] idx);
    return {grp, idx};
  endfunction

  // One request on port g, wait for acceptance and the response
  task automatic access(int g, mem_op_e op, logic [AddrWidth-1:0] addr,
                        logic [DataWidth-1:0] wdata);
    logic [DataWidth-1:0] expected;
    bit                   known;
    @(posedge clk_i);
    req_valid_i[g] <= 1'b1;
    req_op_i[g]    <= op;
    req_addr_i[g]  <= addr;
    req_wdata_i[g] <= wdata;
    @(negedge clk_i);
    while (!req_ready_o[g]) @(negedge clk_i);
    @(posedge clk_i);
    // Accepted on this edge, model follows acceptance order
    known    = model_known[addr] || (op == OP_WRITE);
    expected = (op == OP_WRITE) ? '0 : model_mem[addr];
    if (op != OP_READ) begin
      model_mem[addr]   = wdata;
      model_known[addr] = 1'b1;
    end
    req_valid_i[g] <= 1'b0;
    @(negedge clk_i);
    while (!resp_valid_o[g]) @(negedge clk_i);
    checks++;
    if (known && resp_rdata_o[g] !== expected) begin
      errors++;
      $display("MISMATCH resp_rdata_o[%0d]: got 0x%08h expected 0x%08h",
               g, resp_rdata_o[g], expected);
    end
  endtask

  task automatic local_rw(int g);
    for (int i = 0; i < 4; i++) begin
      access(g, OP_WRITE, make_addr(2'(g), 8'(i)), {8'(g), 8'(i), 16'hA5C3});
    end
    for (int i = 0; i < 4; i++) begin
      access(g, OP_READ, make_addr(2'(g), 8'(i)), '0);
    end
  endtask

  task automatic swap_seq(int g);
    logic [AddrWidth-1:0] addr;
    addr = make_addr(2'(g ^ 2), 8'(32'h80 + g));
    access(g, OP_WRITE, addr, $random(seed));
    access(g, OP_SWAP, addr, $random(seed));
    access(g, OP_READ, addr, '0);
  endtask

  task automatic contention(logic [1:0] bank, mem_op_e op);
    fork
      access(0, op, make_addr(bank, 8'hC0), $random(seed));
      access(1, op, make_addr(bank, 8'hC1), $random(seed));
      access(2, op, make_addr(bank, 8'hC2), $random(seed));
      access(3, op, make_addr(bank, 8'hC3), $random(seed));
    join
  endtask

  // Low index bits carry the port number, so ports never share an address
  task automatic random_traffic(int g);
    logic [31:0] r;
    mem_op_e     op;
    repeat (RandomPerGroup) begin
      r  = $random(seed);
      op = (r[1:0] == 2'd3) ? OP_READ : mem_op_e'(r[1:0]);
      access(g, op, {r[9:8], r[15:10], 2'(g)}, $random(seed));
    end
  endtask

  task automatic report_test(string name);
    tests_run++;
    $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial begin
    seed            = 32'he77b284b;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    cycle_count     = 0;
    errors_at_start = 0;
    arst_n_i        = 1'b0;
    req_valid_i     = '0;
    for (int g = 0; g < NumGroups; g++) begin
      req_op_i[g] = OP_READ;
    end
    req_addr_i      = '0;
    req_wdata_i     = '0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    fork
      local_rw(0);
      local_rw(1);
      local_rw(2);
      local_rw(3);
    join
    report_test("local write and read");

    for (int src = 0; src < NumGroups; src++) begin
      for (int tgt = 0; tgt < NumGroups; tgt++) begin
        access(src, OP_WRITE, make_addr(2'(tgt), 8'(32'h40 + src * 4)), $random(seed));
        access((src + 1) % NumGroups, OP_READ, make_addr(2'(tgt), 8'(32'h40 + src * 4)), '0);
      end
    end
    report_test("remote access on every link");

    fork
      swap_seq(0);
      swap_seq(1);
      swap_seq(2);
      swap_seq(3);
    join
    report_test("swap");

    for (int b = 0; b < NumGroups; b++) begin
      contention(2'(b), OP_WRITE);
      contention(2'(b), OP_READ);
    end
    report_test("contention");

    fork
      random_traffic(0);
      random_traffic(1);
      random_traffic(2);
      random_traffic(3);
    join
    report_test("random traffic");

    // Second reset, contents count as unknown afterwards
    @(posedge clk_i);
    arst_n_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int i = 0; i < NumGroups * BankWords; i++) begin
      model_known[i] = 1'b0;
    end
    access(1, OP_WRITE, make_addr(2'd3, 8'h11), 32'h1234_5678);
    access(2, OP_READ, make_addr(2'd3, 8'h11), '0);
    report_test("reset behavior");

    repeat (2) @(posedge clk_i);
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, checks, errors, i_dut.i_cluster_assertions.fail_count);
    if (errors == 0 && i_dut.i_cluster_assertions.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_memory_cluster

`default_nettype wire

// File: project.f
verilog/cluster_pkg.sv
verilog/group_bank.sv
verilog/group_router.sv
verilog/memory_group.sv
verilog/memory_cluster.sv
verif/cluster_assertions.sv
verif/tb_memory_cluster.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_memory_cluster
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
